// File: hw/quant_config.svh
/*
 * Configuration macros for the 4x4 transform and quantize stage
 *   block geometry and sample widths
 *   quantizer shift and level clamp
 *   coefficient FIFO depth
 */

`ifndef QUANT_CONFIG_SVH
`define QUANT_CONFIG_SVH

// Block geometry
`define QB_NCOEF      16
`define QB_RES_W      9
`define QB_COEF_W     16

// Quantizer arithmetic
`define QB_QSHIFT     17
`define QB_MAX_LEVEL  2047

// Buffering between transform and quantizer, power of two
`define QB_FIFO_DEPTH 4

`endif

// File: hw/quant_pkg.sv
/*
 * Shared types for the transform and quantize stage
 *   residual sample and coefficient scalars
 *   residual and coefficient blocks in raster order
 *   per-position quantization matrix
 *   quantizer result bundle
 */

`include "quant_config.svh"

package quant_pkg;

    // --------------------
    // Scalars
    // --------------------
    typedef logic signed [`QB_RES_W-1:0]  res_smp_t;
    typedef logic signed [`QB_COEF_W-1:0] coef_t;

    // --------------------
    // Blocks
    // --------------------

    // Element 0 is the top left sample, sits in the low bits
    typedef struct packed {
        res_smp_t [`QB_NCOEF-1:0] s;
    } res_blk_t;

    typedef struct packed {
        coef_t [`QB_NCOEF-1:0] c;
    } coef_blk_t;

    // Quantizer settings, one entry per raster position
    typedef struct packed {
        logic [`QB_NCOEF-1:0][15:0] q;
        logic [`QB_NCOEF-1:0][15:0] iq;
        logic [`QB_NCOEF-1:0][31:0] bias;
        logic [`QB_NCOEF-1:0][31:0] zthresh;
        logic [`QB_NCOEF-1:0][15:0] sharpen;
    } quant_mtx_t;

    // Levels go out in zigzag order, recon stays raster
    typedef struct packed {
        coef_blk_t levels;
        coef_blk_t recon;
        logic      nz;
    } quant_res_t;

endpackage

// File: hw/fdct4x4.sv
/*
 * VP8 integer forward 4x4 transform
 *   stage one: horizontal pass on each row, registered
 *   stage two: vertical pass on each column, registered
 *   valid strobe delayed by two cycles along with the data
 */

`include "quant_config.svh"

module fdct4x4
    import quant_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      res_vld_i,
    input  res_blk_t  res_i,
    output logic      coef_vld_o,
    output coef_blk_t coef_o
);

    coef_t row_d [`QB_NCOEF];
    coef_t row_q [`QB_NCOEF];
    coef_t col_d [`QB_NCOEF];
    logic  row_vld_q;

    // --------------------
    // Row pass
    // --------------------
    for (genvar r = 0; r < 4; r++) begin : g_row
        logic signed [31:0] a0;
        logic signed [31:0] a1;
        logic signed [31:0] a2;
        logic signed [31:0] a3;

        assign a0 = 32'($signed(res_i.s[4*r+0])) + 32'($signed(res_i.s[4*r+3]));
        assign a1 = 32'($signed(res_i.s[4*r+1])) + 32'($signed(res_i.s[4*r+2]));
        assign a2 = 32'($signed(res_i.s[4*r+1])) - 32'($signed(res_i.s[4*r+2]));
        assign a3 = 32'($signed(res_i.s[4*r+0])) - 32'($signed(res_i.s[4*r+3]));

        // Even terms scaled by 8, odd terms rotated
        assign row_d[4*r+0] = coef_t'((a0 + a1) * 8);
        assign row_d[4*r+1] = coef_t'((a2 * 2217 + a3 * 5352 + 1812) >>> 9);
        assign row_d[4*r+2] = coef_t'((a0 - a1) * 8);
        assign row_d[4*r+3] = coef_t'((a3 * 2217 - a2 * 5352 + 937) >>> 9);
    end

    // --------------------
    // Column pass
    // --------------------
    for (genvar c = 0; c < 4; c++) begin : g_col
        logic signed [31:0] b0;
        logic signed [31:0] b1;
        logic signed [31:0] b2;
        logic signed [31:0] b3;
        logic signed [31:0] odd1;

        assign b0 = 32'(row_q[c]) + 32'(row_q[12+c]);
        assign b1 = 32'(row_q[4+c]) + 32'(row_q[8+c]);
        assign b2 = 32'(row_q[4+c]) - 32'(row_q[8+c]);
        assign b3 = 32'(row_q[c]) - 32'(row_q[12+c]);

        assign odd1 = (b2 * 2217 + b3 * 5352 + 12000) >>> 16;

        assign col_d[c]    = coef_t'((b0 + b1 + 7) >>> 4);
        // Row 1 gets a one bit bump whenever the difference term is nonzero
        assign col_d[4+c]  = coef_t'(odd1 + ((b3 != 0) ? 32'sd1 : 32'sd0));
        assign col_d[8+c]  = coef_t'((b0 - b1 + 7) >>> 4);
        assign col_d[12+c] = coef_t'((b3 * 2217 - b2 * 5352 + 51000) >>> 16);
    end

    // Strobe pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_vld_q  <= 1'b0;
            coef_vld_o <= 1'b0;
        end else begin
            row_vld_q  <= res_vld_i;
            coef_vld_o <= row_vld_q;
        end
    end

    // Data pipeline, loads only with a valid block
    always_ff @(posedge clk) begin
        if (res_vld_i) begin
            row_q <= row_d;
        end
        if (row_vld_q) begin
            for (int k = 0; k < `QB_NCOEF; k++) begin
                coef_o.c[k] <= col_d[k];
            end
        end
    end

endmodule

// File: hw/block_fifo.sv
/*
 * Coefficient block FIFO
 *   circular buffer with read and write pointers and a count
 *   registered read port, data valid the cycle after pop
 *   pushes while full are dropped and latch a sticky overflow
 */

`include "quant_config.svh"

module block_fifo
    import quant_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      push_i,
    input  coef_blk_t wr_i,
    input  logic      pop_i,
    output coef_blk_t rd_o,
    output logic      rd_vld_o,
    output logic      empty_o,
    output logic      full_o,
    output logic      overflow_o
);

    localparam int PTR_W = $clog2(`QB_FIFO_DEPTH);

    coef_blk_t        mem [`QB_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;

    assign full_o  = (count == (PTR_W + 1)'(`QB_FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign wr_en   = push_i && !full_o;

    // --------------------
    // Pointers and flags
    // --------------------
    // Pop is trusted to arrive only when not empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_vld_o   <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            rd_vld_o <= pop_i;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push_i && full_o) begin
                overflow_o <= 1'b1;
            end
        end
    end

    // Storage and read register
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_i;
        end
        if (pop_i) begin
            rd_o <= mem[rd_ptr];
        end
    end

endmodule

// File: hw/quantize_block.sv
/*
 * 4x4 coefficient quantizer
 *   pops the FIFO while draining is enabled
 *   stage one: sign, sharpened magnitude and scaled level
 *   stage two: clamp, sign restore, zero threshold, dequantize
 *   zigzag level output and nonzero flag
 */

`include "quant_config.svh"

module quantize_block
    import quant_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       drain_en_i,
    input  logic       empty_i,
    output logic       pop_o,
    input  logic       start_i,
    input  coef_blk_t  coef_i,
    input  quant_mtx_t mtx_i,
    output quant_res_t res_o,
    output logic       done_o
);

    localparam int CW    = `QB_COEF_W;
    localparam int LVL_W = 48 - `QB_QSHIFT;
    localparam int MAXL  = `QB_MAX_LEVEL;
    localparam int ZZ [`QB_NCOEF] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    // Stage one
    logic             sgn_d  [`QB_NCOEF];
    logic [31:0]      mag_d  [`QB_NCOEF];
    logic [LVL_W-1:0] lvl_d  [`QB_NCOEF];
    logic             s1_sgn [`QB_NCOEF];
    logic [31:0]      s1_mag [`QB_NCOEF];
    logic [LVL_W-1:0] s1_lvl [`QB_NCOEF];
    logic             s1_vld;

    // Stage two
    coef_t lvl2_d [`QB_NCOEF];
    coef_t rec2_d [`QB_NCOEF];
    coef_t lvl_q  [`QB_NCOEF];
    coef_t rec_q  [`QB_NCOEF];

    assign pop_o = drain_en_i && !empty_i;

    // --------------------
    // Per coefficient math
    // --------------------
    for (genvar i = 0; i < `QB_NCOEF; i++) begin : g_coef
        coef_t              c;
        logic [CW-1:0]      abs_c;
        logic [47:0]        acc;
        logic [CW-1:0]      clamped;
        coef_t              lvl_s;
        logic signed [31:0] rec_full;
        logic               keep;

        assign c        = coef_i.c[i];
        assign sgn_d[i] = c[CW-1];
        assign abs_c    = sgn_d[i] ? CW'(-c) : CW'(c);
        assign mag_d[i] = 32'(abs_c) + 32'(mtx_i.sharpen[i]);

        // Operands are non-negative so the shift needs no sign fill
        assign acc      = 48'(mag_d[i]) * 48'(mtx_i.iq[i]) + 48'(mtx_i.bias[i]);
        assign lvl_d[i] = acc[47:`QB_QSHIFT];

        assign clamped  = (s1_lvl[i] > LVL_W'(MAXL)) ? CW'(MAXL) : CW'(s1_lvl[i]);
        assign lvl_s    = s1_sgn[i] ? -coef_t'(clamped) : coef_t'(clamped);
        assign keep     = s1_mag[i] > mtx_i.zthresh[i];
        assign rec_full = 32'(lvl_s) * $signed({16'b0, mtx_i.q[i]});

        // Dead zone
        assign lvl2_d[i] = keep ? lvl_s : '0;
        assign rec2_d[i] = keep ? coef_t'(rec_full) : '0;
    end

    // --------------------
    // Pipeline registers
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            done_o <= 1'b0;
        end else begin
            s1_vld <= start_i;
            done_o <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            s1_sgn <= sgn_d;
            s1_mag <= mag_d;
            s1_lvl <= lvl_d;
        end
        if (s1_vld) begin
            lvl_q <= lvl2_d;
            rec_q <= rec2_d;
        end
    end

    // Output packing, zigzag on levels only
    always_comb begin
        logic any_nz;
        any_nz = 1'b0;
        for (int k = 0; k < `QB_NCOEF; k++) begin
            res_o.levels.c[k] = lvl_q[ZZ[k]];
            res_o.recon.c[k]  = rec_q[k];
            any_nz            = any_nz | (lvl_q[k] != '0);
        end
        res_o.nz = any_nz;
    end

endmodule

// File: hw/quant_top.sv
/*
 * Transform and quantize stage top level
 *   forward transform feeding the block FIFO
 *   quantizer draining the FIFO under drain_en_i
 */

`include "quant_config.svh"

module quant_top
    import quant_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       res_vld_i,
    input  res_blk_t   res_i,
    input  quant_mtx_t mtx_i,
    input  logic       drain_en_i,
    output quant_res_t res_o,
    output logic       done_o,
    output logic       fifo_full_o,
    output logic       overflow_o
);

    // Transform to FIFO
    logic      coef_vld;
    coef_blk_t coef_blk;

    // FIFO to quantizer
    coef_blk_t fifo_rd;
    logic      rd_vld;
    logic      fifo_empty;
    logic      pop;

    // --------------------
    // Transform
    // --------------------
    fdct4x4 u_fdct (
        .clk        (clk),
        .rst_n      (rst_n),
        .res_vld_i  (res_vld_i),
        .res_i      (res_i),
        .coef_vld_o (coef_vld),
        .coef_o     (coef_blk)
    );

    // --------------------
    // Buffer
    // --------------------
    block_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_i     (coef_vld),
        .wr_i       (coef_blk),
        .pop_i      (pop),
        .rd_o       (fifo_rd),
        .rd_vld_o   (rd_vld),
        .empty_o    (fifo_empty),
        .full_o     (fifo_full_o),
        .overflow_o (overflow_o)
    );

    // --------------------
    // Quantizer
    // --------------------
    quantize_block u_quant (
        .clk        (clk),
        .rst_n      (rst_n),
        .drain_en_i (drain_en_i),
        .empty_i    (fifo_empty),
        .pop_o      (pop),
        .start_i    (rd_vld),
        .coef_i     (fifo_rd),
        .mtx_i      (mtx_i),
        .res_o      (res_o),
        .done_o     (done_o)
    );

endmodule

// File: tb/quant_chk.sv
/*
 * Bound checker for the quantizer and the block FIFO
 *   done follows start by two cycles
 *   no pop while empty, never full and empty together
 *   sticky overflow
 */

module quant_chk (
    input logic clk,
    input logic rst_n,
    input logic start_i,
    input logic done_i,
    input logic pop_i,
    input logic empty_i,
    input logic full_i,
    input logic overflow_i
);
    timeunit 1ns;
    timeprecision 100ps;

    a_done_lat: assert property (@(posedge clk) disable iff (!rst_n) start_i |-> ##2 done_i)
        else $error("done did not follow start by two cycles");

    a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop_i && empty_i))
        else $error("pop while empty");

    a_full_empty: assert property (@(posedge clk) disable iff (!rst_n) !(full_i && empty_i))
        else $error("full and empty both high");

    a_ovf_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(overflow_i))
        else $error("overflow fell without reset");

endmodule

bind quantize_block quant_chk u_chk (
    .clk(clk), .rst_n(rst_n), .start_i(start_i), .done_i(done_o),
    .pop_i(1'b0), .empty_i(1'b0), .full_i(1'b0), .overflow_i(1'b0)
);

bind block_fifo quant_chk u_chk (
    .clk(clk), .rst_n(rst_n), .start_i(1'b0), .done_i(1'b0),
    .pop_i(pop_i), .empty_i(empty_o), .full_i(full_o), .overflow_i(overflow_o)
);

// File: tb/quant_tb.sv
/*
 * Testbench for the transform and quantize stage
 *   reference transform and quantizer models
 *   directed table rows, random burst, FIFO fill and release
 *   results compared against a queue of expected blocks
 */

`include "quant_config.svh"

module quant_tb
    import quant_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        res_blk_t   res;
        logic [1:0] sel;
        logic       drain;
        logic       exp_nz;
        logic       exp_full;
        logic       exp_ovf;
    } row_t;

    localparam int ZZ_ORDER [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    logic       clk;
    logic       rst_n;
    logic       res_vld_i;
    res_blk_t   res_i;
    quant_mtx_t mtx_i;
    logic       drain_en_i;
    quant_res_t res_o;
    logic       done_o;
    logic       fifo_full_o;
    logic       overflow_o;

    quant_mtx_t mtx_tab [3];
    row_t       tab [10];
    quant_res_t exp_q [$];
    quant_res_t exp_blk;
    int         seed;
    int         errors;
    int         n_tests;
    int         n_bad;
    int         run_len;
    int         max_run;

    quant_top dut (.*);

    always #5 clk = ~clk;

    // --------------------
    // Reference models
    // --------------------
    function automatic coef_blk_t fdct_model(res_blk_t r);
        int t [16];
        int a0, a1, a2, a3;
        coef_blk_t o;
        for (int i = 0; i < 4; i++) begin
            a0 = int'(r.s[4*i]) + int'(r.s[4*i+3]);
            a1 = int'(r.s[4*i+1]) + int'(r.s[4*i+2]);
            a2 = int'(r.s[4*i+1]) - int'(r.s[4*i+2]);
            a3 = int'(r.s[4*i]) - int'(r.s[4*i+3]);
            t[4*i]   = (a0 + a1) * 8;
            t[4*i+1] = (a2 * 2217 + a3 * 5352 + 1812) >>> 9;
            t[4*i+2] = (a0 - a1) * 8;
            t[4*i+3] = (a3 * 2217 - a2 * 5352 + 937) >>> 9;
        end
        for (int c = 0; c < 4; c++) begin
            a0 = t[c] + t[12+c];
            a1 = t[4+c] + t[8+c];
            a2 = t[4+c] - t[8+c];
            a3 = t[c] - t[12+c];
            o.c[c]    = coef_t'((a0 + a1 + 7) >>> 4);
            o.c[4+c]  = coef_t'(((a2 * 2217 + a3 * 5352 + 12000) >>> 16) + (a3 != 0 ? 1 : 0));
            o.c[8+c]  = coef_t'((a0 - a1 + 7) >>> 4);
            o.c[12+c] = coef_t'((a3 * 2217 - a2 * 5352 + 51000) >>> 16);
        end
        return o;
    endfunction

    function automatic quant_res_t quant_model(coef_blk_t cb, quant_mtx_t m);
        longint c, mag, lv;
        coef_t lvl [16];
        quant_res_t o;
        o.nz = 1'b0;
        for (int i = 0; i < 16; i++) begin
            c   = longint'(cb.c[i]);
            mag = ((c < 0) ? -c : c) + longint'(m.sharpen[i]);
            lv  = (mag * longint'(m.iq[i]) + longint'(m.bias[i])) >>> `QB_QSHIFT;
            if (lv > `QB_MAX_LEVEL)
                lv = `QB_MAX_LEVEL;
            if (c < 0)
                lv = -lv;
            // Dead zone on the sharpened magnitude
            if (mag <= longint'(m.zthresh[i]))
                lv = 0;
            lvl[i]       = coef_t'(lv);
            o.recon.c[i] = coef_t'(lv * longint'(m.q[i]));
            if (lv != 0)
                o.nz = 1'b1;
        end
        for (int k = 0; k < 16; k++) begin
            o.levels.c[k] = lvl[ZZ_ORDER[k]];
        end
        return o;
    endfunction

    // --------------------
    // Stimulus helpers
    // --------------------
    function automatic res_blk_t ramp_blk(int base, int step);
        res_blk_t b;
        for (int k = 0; k < 16; k++) begin
            b.s[k] = res_smp_t'(base + k * step);
        end
        return b;
    endfunction

    function automatic res_blk_t rand_blk();
        res_blk_t b;
        for (int k = 0; k < 16; k++) begin
            b.s[k] = res_smp_t'($random(seed) % 256);
        end
        return b;
    endfunction

    function automatic quant_mtx_t make_mtx(int q0, int qinc, int iq, int bias, int zth, int shp);
        quant_mtx_t m;
        for (int i = 0; i < 16; i++) begin
            m.q[i]       = 16'(q0 + i * qinc);
            m.iq[i]      = (iq == 0) ? 16'(131072 / (q0 + i * qinc)) : 16'(iq);
            m.bias[i]    = 32'(bias);
            m.zthresh[i] = 32'(zth);
            m.sharpen[i] = 16'(shp);
        end
        return m;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_levels(string sig, coef_blk_t got, coef_blk_t exp);
        if (got !== exp) begin
            $display("error t=%0t %s got %h exp %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_recon(string sig, coef_blk_t got, coef_blk_t exp);
        if (got !== exp) begin
            $display("error t=%0t %s got %h exp %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string sig, logic got, logic exp);
        if (got !== exp) begin
            $display("error t=%0t %s got %b exp %b", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(string why);
        $display("%s at t=%0t", why, $time);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic end_test(string name, int err0);
        n_tests++;
        if (errors == err0) begin
            $display("test %0d %s: pass", n_tests, name);
        end else begin
            n_bad++;
            $display("test %0d %s: fail with %0d errors", n_tests, name, errors - err0);
        end
    endtask

    // Result monitor, values sampled before the edge updates them
    always @(posedge clk) begin
        run_len = (rst_n && done_o) ? run_len + 1 : 0;
        if (run_len > max_run)
            max_run = run_len;
        if (rst_n && done_o) begin
            if (exp_q.size() == 0) begin
                $display("error t=%0t done_o pulsed with no block outstanding", $time);
                errors++;
            end else begin
                exp_blk = exp_q.pop_front();
                check_levels("res_o.levels", res_o.levels, exp_blk.levels);
                check_recon("res_o.recon", res_o.recon, exp_blk.recon);
                check_flag("res_o.nz", res_o.nz, exp_blk.nz);
            end
        end
    end

    // --------------------
    // Test tasks
    // --------------------
    task automatic send_block(res_blk_t r, int sel, bit keep);
        res_i     = r;
        mtx_i     = mtx_tab[sel];
        res_vld_i = 1'b1;
        if (keep)
            exp_q.push_back(quant_model(fdct_model(r), mtx_tab[sel]));
        @(posedge clk);
        #1;
        res_vld_i = 1'b0;
    endtask

    task automatic wait_drained(int limit);
        int cyc;
        cyc = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            cyc++;
            if (cyc > limit)
                abort_run("timeout waiting for outstanding blocks to come out");
        end
    endtask

    task automatic run_single(row_t row, string name);
        int cyc;
        int err0;
        err0       = errors;
        drain_en_i = 1'b1;
        send_block(row.res, row.sel, 1'b1);
        cyc = 1;
        while (done_o !== 1'b1) begin
            @(posedge clk);
            #1;
            cyc++;
            if (cyc > 40)
                abort_run("timeout waiting for done_o");
        end
        if (cyc != 6) begin
            $display("error t=%0t done_o latency got %0d exp 6", $time, cyc);
            errors++;
        end
        check_flag("res_o.nz", res_o.nz, row.exp_nz);
        @(posedge clk);
        #1;
        end_test(name, err0);
    endtask

    task automatic run_held(row_t row, string name);
        int err0;
        err0       = errors;
        drain_en_i = 1'b0;
        send_block(row.res, row.sel, !row.exp_ovf);
        // Push lands two edges after the strobe is taken
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        check_flag("fifo_full_o", fifo_full_o, row.exp_full);
        check_flag("overflow_o", overflow_o, row.exp_ovf);
        end_test(name, err0);
    endtask

    task automatic run_burst(int n);
        int err0;
        err0       = errors;
        drain_en_i = 1'b1;
        max_run    = 0;
        for (int k = 0; k < n; k++) begin
            send_block(rand_blk(), 0, 1'b1);
        end
        wait_drained(40);
        if (max_run != n) begin
            $display("error t=%0t done_o run length got %0d exp %0d", $time, max_run, n);
            errors++;
        end
        end_test("random burst", err0);
    endtask

    task automatic release_fifo();
        int err0;
        err0       = errors;
        drain_en_i = 1'b1;
        wait_drained(40);
        // Dropped block must never show up
        repeat (10) begin
            @(posedge clk);
            #1;
        end
        end_test("fifo release", err0);
    endtask

    task automatic fill_table();
        tab[0] = '{ramp_blk(0, 0), 2'd1, 1'b1, 1'b0, 1'b0, 1'b0};
        tab[1] = '{ramp_blk(3, 0), 2'd1, 1'b1, 1'b0, 1'b0, 1'b0};
        tab[2] = '{ramp_blk(10, 0), 2'd0, 1'b1, 1'b1, 1'b0, 1'b0};
        tab[3] = '{ramp_blk(-255, 34), 2'd2, 1'b1, 1'b1, 1'b0, 1'b0};
        tab[4] = '{ramp_blk(100, -13), 2'd0, 1'b1, 1'b1, 1'b0, 1'b0};
        for (int k = 0; k < 5; k++) begin
            tab[5+k] = '{ramp_blk(k * 20 - 50, 7), 2'd0, 1'b0, 1'b1, k >= 3, k == 4};
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        seed       = 32'hc750;
        clk        = 1'b0;
        rst_n      = 1'b0;
        res_vld_i  = 1'b0;
        res_i      = '0;
        mtx_i      = '0;
        drain_en_i = 1'b0;
        errors     = 0;
        n_tests    = 0;
        n_bad      = 0;
        run_len    = 0;
        max_run    = 0;
        mtx_tab[0] = make_mtx(20, 1, 0, 1 << 16, 9, 0);
        mtx_tab[1] = make_mtx(20, 0, 0, 1 << 16, 100000, 0);
        mtx_tab[2] = make_mtx(1, 0, 65535, 0, 0, 4096);
        fill_table();

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("done_o", done_o, 1'b0);
        check_flag("fifo_full_o", fifo_full_o, 1'b0);
        check_flag("overflow_o", overflow_o, 1'b0);
        end_test("reset state", 0);

        run_burst(6);
        for (int i = 0; i < 10; i++) begin
            if (tab[i].drain)
                run_single(tab[i], $sformatf("row %0d", i));
            else
                run_held(tab[i], $sformatf("row %0d", i));
        end
        release_fifo();

        $display("tests %0d failed %0d errors %0d", n_tests, n_bad, errors);
        if (errors == 0 && n_bad == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hw
hw/quant_pkg.sv
hw/fdct4x4.sv
hw/block_fifo.sv
hw/quantize_block.sv
hw/quant_top.sv
tb/quant_chk.sv
tb/quant_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the transform and quantize testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module quant_tb -f sources.f -o Vquant_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vquant_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
